//--- ctrlport_cases.txt
# pair mst op addr data be exp_data status lat rank  (addr, data, be, exp_data in hex)
# pair 1 launches with the next line; op 1 wr, 0 rd; status 0 OKAY 1 CMDERR 3 SLVERR; lat 0 unchecked
0 0 0 00000 00000000 f 00000300 0 0 0
0 0 1 00000 ffffffff f 00000000 0 0 0
0 0 0 00000 00000000 f 00000301 0 3 0
0 0 1 00004 11223344 f 00000000 0 3 0
0 0 1 00004 aabbccdd 5 00000000 0 3 0
0 1 0 00004 00000000 f 11bb33dd 0 0 0
0 0 1 00100 cafef00d f 00000000 0 4 0
0 0 1 00100 12345678 a 00000000 0 4 0
0 1 0 00100 00000000 f 12fe560d 0 0 0
0 1 1 001fc 0badbeef f 00000000 0 0 0
0 0 0 001fc 00000000 f 0badbeef 0 4 0
1 0 1 00104 55555555 f 00000000 0 0 0
2 1 1 00108 66666666 f 00000000 0 0 1
1 0 0 00104 00000000 f 55555555 0 0 0
2 1 0 00108 00000000 f 66666666 0 0 1
0 0 1 00000 00000300 f 00000000 0 0 0
1 0 0 00004 00000000 f 11bb33dd 0 0 1
2 1 0 00104 00000000 f 55555555 0 0 0
0 1 0 00108 00000000 f 66666666 0 0 0
1 0 1 00008 77777777 f 00000000 0 0 0
2 1 1 0010c 88888888 f 00000000 0 0 1
1 0 0 00008 00000000 f 77777777 0 0 0
2 1 0 0010c 00000000 f 88888888 0 0 1
0 0 1 00000 00000100 f 00000000 0 0 0
0 1 1 00100 deaddead f 00000000 1 1 0
0 1 0 00004 00000000 f 00000000 1 1 0
0 0 0 00100 00000000 f 12fe560d 0 0 0
0 0 1 00000 00000301 3 00000000 0 0 0
0 0 0 00300 00000000 f 00000000 3 3 0
0 1 1 80000 12345678 f 00000000 3 0 0
0 0 0 00020 00000000 f 00000000 3 3 0
0 1 1 00014 ffffffff f 00000000 3 0 0
0 0 0 00000 00000000 f 00000301 0 3 0

//--- all.f
+incdir+.
ctrlport_pkg.sv
subsys_regs_pkg.sv
ctrlport_if.sv
ctrlport_arbiter.sv
ctrlport_decoder.sv
ctrlport_cfg_regs.sv
ctrlport_ram.sv
ctrlport_subsys.sv
ctrlport_subsys_chk.sv
tb_ctrlport_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the control-port subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_ctrlport_subsys -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- tb_ctrlport_subsys.sv
// **************************************************
// Testbench for the control-port subsystem, driven
// from a case file by two master drivers
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

module tb_ctrlport_subsys
  import ctrlport_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N  = `CTRLPORT_NUM_MASTERS;
  localparam int MW = (N > 1) ? $clog2(N) : 1;
  localparam int AW = `CTRLPORT_ADDR_W;
  localparam int DW = `CTRLPORT_DATA_W;
  localparam int BW = `CTRLPORT_BYTE_EN_W;
  localparam int SW = $bits(ctrlport_status_t);
  localparam int CYCLES_PER_CASE = 40;

  // One line of the case file
  typedef struct {
    int                num;
    int                pair;
    int                mst;
    int                op;
    ctrlport_addr_t    addr;
    ctrlport_data_t    data;
    ctrlport_byte_en_t byte_en;
    ctrlport_data_t    exp_data;
    ctrlport_status_t  exp_status;
    int                lat;
    int                rank;
  } case_t;

  logic            ctrlport_clk;
  logic            arst_n;
  logic [N-1:0]    req_wr;
  logic [N-1:0]    req_rd;
  logic [AW*N-1:0] req_addr;
  logic [DW*N-1:0] req_data;
  logic [BW*N-1:0] req_byte_en;
  logic [N-1:0]    resp_ack;
  logic [SW*N-1:0] resp_status;
  logic [DW*N-1:0] resp_data;

  case_t cases [$];
  int    err_count;
  int    pass_count;
  int    fail_count;
  int    load_errors;
  // Ack arrival position inside the current group
  int    ack_order;

  ctrlport_subsys DUT (
    .ctrlport_clk (ctrlport_clk),
    .arst_n       (arst_n),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_byte_en  (req_byte_en),
    .resp_ack     (resp_ack),
    .resp_status  (resp_status),
    .resp_data    (resp_data)
  );

  initial begin
    ctrlport_clk = 1'b0;
    forever #4 ctrlport_clk = ~ctrlport_clk;
  end

  task automatic check_status(input ctrlport_status_t got, input ctrlport_status_t exp,
                              input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
      err_count++;
    end
  endtask

  task automatic check_data(input ctrlport_data_t got, input ctrlport_data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %08h, expected %08h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // Parse the case file, lines starting with # are notes
  task automatic load_cases();
    int          fd;
    int          n;
    int          line_no;
    string       line;
    case_t       c;
    logic [31:0] addr, data, be, exp_data, sts;
    fd = $fopen("ctrlport_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file ctrlport_cases.txt");
      load_errors++;
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%d %d %d %h %h %h %h %d %d %d", c.pair, c.mst, c.op,
                  addr, data, be, exp_data, sts, c.lat, c.rank);
      if (n != 10 || c.mst >= N) begin
        $display("Case file line %0d could not be parsed", line_no);
        load_errors++;
        continue;
      end
      c.num        = cases.size();
      c.addr       = addr[AW-1:0];
      c.data       = data[DW-1:0];
      c.byte_en    = be[BW-1:0];
      c.exp_data   = exp_data[DW-1:0];
      c.exp_status = ctrlport_status_t'(sts[1:0]);
      cases.push_back(c);
    end
    $fclose(fd);
  endtask

  // One-cycle strobe, then wait on this master's ack
  task automatic run_case(input case_t c);
    logic [MW-1:0]    m;
    int               lat;
    int               rank;
    int               errs_before;
    ctrlport_status_t got_status;
    ctrlport_data_t   got_data;
    m = MW'(c.mst);
    req_wr[m] = (c.op == 1);
    req_rd[m] = (c.op == 0);
    req_addr[AW*m +: AW]   = c.addr;
    req_data[DW*m +: DW]   = c.data;
    req_byte_en[BW*m +: BW] = c.byte_en;
    @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    req_wr[m] = 1'b0;
    req_rd[m] = 1'b0;
    // Cycles counted from the strobe cycle
    lat = 1;
    while (resp_ack[m] !== 1'b1) begin
      @(negedge ctrlport_clk);
      lat++;
    end
    got_status = ctrlport_status_t'(resp_status[SW*m +: SW]);
    got_data   = resp_data[DW*m +: DW];
    rank = ack_order;
    ack_order++;
    errs_before = err_count;
    check_status(got_status, c.exp_status, $sformatf("case %0d status", c.num));
    check_data(got_data, c.exp_data, $sformatf("case %0d data", c.num));
    if (c.lat != 0 && lat != c.lat) begin
      $display("Case %0d: master %0d got its ack %0d cycles after the strobe, expected %0d",
               c.num, c.mst, lat, c.lat);
      err_count++;
    end
    // Ack order only means something when both masters launched together
    if (c.pair != 0 && rank != c.rank) begin
      $display("Case %0d: master %0d was acked in position %0d of its group, expected %0d",
               c.num, c.mst, rank, c.rank);
      err_count++;
    end
    if (err_count == errs_before) begin
      pass_count++;
      $display("[PASS] case %0d: master %0d %s %05h, %s after %0d cycles",
               c.num, c.mst, (c.op == 1) ? "wr" : "rd", c.addr, got_status.name(), lat);
    end else begin
      fail_count++;
      $display("[FAIL] case %0d: master %0d %s %05h",
               c.num, c.mst, (c.op == 1) ? "wr" : "rd", c.addr);
    end
  endtask

  task automatic watchdog(input int limit);
    repeat (limit) @(posedge ctrlport_clk);
    $display("Timeout after %0d cycles, a master never received its ack", limit);
    $display("Simulation FAILED");
    $finish;
  endtask

  initial begin
    int i;
    int gap;
    int chk_errors;
    arst_n      = 1'b0;
    req_wr      = '0;
    req_rd      = '0;
    req_addr    = '0;
    req_data    = '0;
    req_byte_en = '0;
    err_count   = 0;
    pass_count  = 0;
    fail_count  = 0;
    load_errors = 0;
    ack_order   = 0;
    void'($urandom(25));
    load_cases();
    if (cases.size() > 0) begin
      fork
        watchdog(cases.size() * CYCLES_PER_CASE);
      join_none
    end
    repeat (10) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    arst_n = 1'b1;
    i = 0;
    while (i < cases.size()) begin
      // Next strobe starts past the previous ack cycle, then an idle gap
      gap = $urandom % 4;
      repeat (gap + 1) @(negedge ctrlport_clk);
      ack_order = 0;
      if (cases[i].pair == 1 && i + 1 < cases.size()) begin
        // Both masters strobe in the same cycle
        fork
          run_case(cases[i]);
          run_case(cases[i+1]);
        join
        i += 2;
      end else begin
        run_case(cases[i]);
        i++;
      end
    end
    repeat (2) @(negedge ctrlport_clk);
    chk_errors = DUT.u_arbiter.u_chk.assert_errors;
    $display("Summary: %0d cases, %0d passed, %0d failed, %0d check errors, %0d assertion errors",
             cases.size(), pass_count, fail_count, err_count, chk_errors);
    if (cases.size() > 0 && fail_count == 0 && err_count == 0 && load_errors == 0 &&
        chk_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ctrlport_subsys_chk.sv
// **************************************************
// Handshake assertions bound into the arbiter
// **************************************************
`default_nettype none

module ctrlport_subsys_chk #(
  parameter int NUM_MASTERS = 2
) (
  input logic                   ctrlport_clk,
  input logic                   arst_n,
  input logic [NUM_MASTERS-1:0] strobe,
  input logic [NUM_MASTERS-1:0] ack,
  input logic                   ds_wr,
  input logic                   ds_rd,
  input logic                   ds_ack
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failures seen so far, read back by the testbench
  int assert_errors = 0;

  logic [NUM_MASTERS-1:0] open_req;
  logic                   ds_open;

  // Requests seen and not yet acked, per master and downstream
  always_ff @(posedge ctrlport_clk or negedge arst_n) begin
    if (!arst_n) begin
      open_req <= '0;
      ds_open  <= 1'b0;
    end else begin
      open_req <= (open_req | strobe) & ~ack;
      ds_open  <= (ds_open | ds_wr | ds_rd) & ~ds_ack;
    end
  end

  a_ds_excl: assert property (@(posedge ctrlport_clk) disable iff (!arst_n)
    !(ds_wr && ds_rd))
    else begin
      assert_errors++;
      $error("downstream wr and rd high in the same cycle");
    end

  a_ack_onehot: assert property (@(posedge ctrlport_clk) disable iff (!arst_n)
    $onehot0(ack))
    else begin
      assert_errors++;
      $error("more than one master ack in one cycle");
    end

  for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_mst
    a_ack_after_req: assert property (@(posedge ctrlport_clk) disable iff (!arst_n)
      ack[i] |-> open_req[i])
      else begin
        assert_errors++;
        $error("master %0d acked without a pending request", i);
      end
  end

  // No second strobe while the first waits for its ack
  a_ds_no_repeat: assert property (@(posedge ctrlport_clk) disable iff (!arst_n)
    (ds_wr || ds_rd) |-> !ds_open)
    else begin
      assert_errors++;
      $error("downstream strobe repeated before its ack");
    end

endmodule

bind ctrlport_arbiter ctrlport_subsys_chk #(
  .NUM_MASTERS (NUM_MASTERS)
) u_chk (
  .ctrlport_clk (ctrlport_clk),
  .arst_n       (arst_n),
  .strobe       (strobe),
  .ack          (ack_q),
  .ds_wr        (ds_wr),
  .ds_rd        (ds_rd),
  .ds_ack       (ds_ack)
);

`default_nettype wire

//--- ctrlport_subsys.sv
// **************************************************
// Control-port subsystem top: arbiter, decoder, regs, RAM
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

module ctrlport_subsys
  import ctrlport_pkg::*;
  import subsys_regs_pkg::*;
(
  input  logic ctrlport_clk,
  input  logic arst_n,
  // Flat per-master requests
  input  logic [`CTRLPORT_NUM_MASTERS-1:0]                    req_wr,
  input  logic [`CTRLPORT_NUM_MASTERS-1:0]                    req_rd,
  input  logic [`CTRLPORT_ADDR_W*`CTRLPORT_NUM_MASTERS-1:0]   req_addr,
  input  logic [`CTRLPORT_DATA_W*`CTRLPORT_NUM_MASTERS-1:0]   req_data,
  input  logic [`CTRLPORT_BYTE_EN_W*`CTRLPORT_NUM_MASTERS-1:0] req_byte_en,
  // Flat per-master responses
  output logic [`CTRLPORT_NUM_MASTERS-1:0]                    resp_ack,
  output logic [$bits(ctrlport_status_t)*`CTRLPORT_NUM_MASTERS-1:0] resp_status,
  output logic [`CTRLPORT_DATA_W*`CTRLPORT_NUM_MASTERS-1:0]   resp_data
);

  localparam int N     = `CTRLPORT_NUM_MASTERS;
  localparam int AW    = `CTRLPORT_ADDR_W;
  localparam int DW    = `CTRLPORT_DATA_W;
  localparam int BW    = `CTRLPORT_BYTE_EN_W;
  localparam int STS_W = $bits(ctrlport_status_t);

  ctrlport_if mst_ctrlport [N] ();
  ctrlport_if arb_ctrlport ();
  ctrlport_if cfg_ctrlport ();
  ctrlport_if ram_ctrlport ();

  // Arbiter steering from the config block
  arb_mode_t      arb_mode;
  logic [N-1:0]   master_en;

  // Slice the flat vectors onto one link per master
  for (genvar i = 0; i < N; i++) begin : g_map
    assign mst_ctrlport[i].req = '{wr: req_wr[i], rd: req_rd[i],
                                   addr: req_addr[AW*i +: AW],
                                   data: req_data[DW*i +: DW],
                                   byte_en: req_byte_en[BW*i +: BW]};
    assign resp_ack[i]                   = mst_ctrlport[i].resp.ack;
    assign resp_status[STS_W*i +: STS_W] = mst_ctrlport[i].resp.status;
    assign resp_data[DW*i +: DW]         = mst_ctrlport[i].resp.data;
  end

  ctrlport_arbiter #(
    .NUM_MASTERS (N)
  ) u_arbiter (
    .ctrlport_clk (ctrlport_clk),
    .arst_n       (arst_n),
    .s_ctrlport   (mst_ctrlport),
    .m_ctrlport   (arb_ctrlport),
    .mode         (arb_mode),
    .master_en    (master_en)
  );

  ctrlport_decoder u_decoder (
    .ctrlport_clk (ctrlport_clk),
    .arst_n       (arst_n),
    .s_ctrlport   (arb_ctrlport),
    .cfg_ctrlport (cfg_ctrlport),
    .ram_ctrlport (ram_ctrlport)
  );

  ctrlport_cfg_regs u_cfg_regs (
    .ctrlport_clk (ctrlport_clk),
    .arst_n       (arst_n),
    .s_ctrlport   (cfg_ctrlport),
    .mode         (arb_mode),
    .master_en    (master_en)
  );

  ctrlport_ram u_ram (
    .ctrlport_clk (ctrlport_clk),
    .arst_n       (arst_n),
    .s_ctrlport   (ram_ctrlport)
  );

endmodule

`default_nettype wire

//--- ctrlport_ram.sv
// **************************************************
// Byte-enabled scratch RAM, acked two cycles later
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

module ctrlport_ram
  import ctrlport_pkg::*;
(
  input  logic      ctrlport_clk,
  input  logic      arst_n,
  ctrlport_if.slave s_ctrlport
);

  localparam int IDX_W = $clog2(`RAM_DEPTH);

  ctrlport_data_t   mem [`RAM_DEPTH];
  logic [IDX_W-1:0] idx;
  logic             strobe, stage_ack, ack_q;
  ctrlport_data_t   stage_data, data_q;

  assign strobe = s_ctrlport.req.wr | s_ctrlport.req.rd;
  // Word index within the window
  assign idx    = s_ctrlport.req.addr[2 +: IDX_W];

  always_ff @(posedge ctrlport_clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_ack <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      stage_ack <= strobe;
      ack_q     <= stage_ack;
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    if (s_ctrlport.req.wr) begin
      mem[idx] <= byte_merge(mem[idx], s_ctrlport.req.data, s_ctrlport.req.byte_en);
    end
    // Read data captured before any write lands, writes return zero
    stage_data <= s_ctrlport.req.rd ? mem[idx] : '0;
    data_q     <= stage_data;
  end

  // Every access to this window succeeds
  assign s_ctrlport.resp = '{ack: ack_q, status: OKAY, data: data_q};

endmodule

`default_nettype wire

//--- ctrlport_cfg_regs.sv
// **************************************************
// Arbiter control and scratch registers
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

module ctrlport_cfg_regs
  import ctrlport_pkg::*;
  import subsys_regs_pkg::*;
(
  input  logic                             ctrlport_clk,
  input  logic                             arst_n,
  ctrlport_if.slave                        s_ctrlport,
  output arb_mode_t                        mode,
  output logic [`CTRLPORT_NUM_MASTERS-1:0] master_en
);

  localparam int SCR_IDX_W = $clog2(`SCRATCH_WORDS);
  localparam logic [`WIN_W-1:0] ARB_OFS = `ARB_CTRL_OFS;
  localparam logic [`WIN_W-1:0] SCR_LO  = `SCRATCH_OFS;
  localparam logic [`WIN_W-1:0] SCR_HI  = `WIN_W'(`SCRATCH_OFS + 4*`SCRATCH_WORDS);

  arb_ctrl_u            arb_ctrl;
  ctrlport_data_t       scratch [`SCRATCH_WORDS];
  logic [`WIN_W-1:0]    ofs;
  logic [`WIN_W-1:0]    scr_rel;
  logic [SCR_IDX_W-1:0] scr_idx;
  logic                 strobe, is_arb, is_scr, ack_q;
  ctrlport_data_t       rd_word, data_q;
  ctrlport_status_t     status_q;

  assign strobe  = s_ctrlport.req.wr | s_ctrlport.req.rd;
  assign ofs     = s_ctrlport.req.addr[`WIN_W-1:0];
  assign scr_rel = ofs - SCR_LO;
  assign scr_idx = scr_rel[2 +: SCR_IDX_W];
  assign is_arb  = ofs == ARB_OFS;
  // Scratch words are word aligned only
  assign is_scr  = (ofs >= SCR_LO) && (ofs < SCR_HI) && (ofs[1:0] == 2'b00);

  // Unused offsets read as zero
  assign rd_word = is_arb ? arb_ctrl.raw : (is_scr ? scratch[scr_idx] : '0);

  always_ff @(posedge ctrlport_clk or negedge arst_n) begin
    if (!arst_n) begin
      arb_ctrl.raw <= ARB_CTRL_RESET;
      ack_q        <= 1'b0;
    end else begin
      ack_q <= strobe;
      // Reserved bits forced low on every write
      if (s_ctrlport.req.wr && is_arb) begin
        arb_ctrl.raw <= byte_merge(arb_ctrl.raw, s_ctrlport.req.data,
                                   s_ctrlport.req.byte_en) & ARB_CTRL_MASK;
      end
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    if (s_ctrlport.req.wr && is_scr) begin
      scratch[scr_idx] <= byte_merge(scratch[scr_idx], s_ctrlport.req.data,
                                     s_ctrlport.req.byte_en);
    end
    if (strobe) begin
      status_q <= (is_arb || is_scr) ? OKAY : SLVERR;
      data_q   <= s_ctrlport.req.rd ? rd_word : '0;
    end
  end

  assign s_ctrlport.resp = '{ack: ack_q, status: status_q, data: data_q};

  // Field view of the same word drives the arbiter
  assign mode      = arb_ctrl.f.mode;
  assign master_en = arb_ctrl.f.master_en;

endmodule

`default_nettype wire

//--- ctrlport_decoder.sv
// **************************************************
// Address decoder steering requests to two targets
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

module ctrlport_decoder
  import ctrlport_pkg::*;
(
  input  logic       ctrlport_clk,
  input  logic       arst_n,
  ctrlport_if.slave  s_ctrlport,
  ctrlport_if.master cfg_ctrlport,
  ctrlport_if.master ram_ctrlport
);

  localparam ctrlport_addr_t CFG_BASE_A = `CFG_BASE;
  localparam ctrlport_addr_t RAM_BASE_A = `RAM_BASE;

  logic strobe, cfg_hit, ram_hit, miss_ack;

  assign strobe  = s_ctrlport.req.wr | s_ctrlport.req.rd;
  // Window match on the bits above the window offset
  assign cfg_hit = s_ctrlport.req.addr[`CTRLPORT_ADDR_W-1:`WIN_W] ==
                   CFG_BASE_A[`CTRLPORT_ADDR_W-1:`WIN_W];
  assign ram_hit = s_ctrlport.req.addr[`CTRLPORT_ADDR_W-1:`WIN_W] ==
                   RAM_BASE_A[`CTRLPORT_ADDR_W-1:`WIN_W];

  // Same fields to both targets, strobes only to the hit one
  always_comb begin
    cfg_ctrlport.req    = s_ctrlport.req;
    cfg_ctrlport.req.wr = s_ctrlport.req.wr & cfg_hit;
    cfg_ctrlport.req.rd = s_ctrlport.req.rd & cfg_hit;
    ram_ctrlport.req    = s_ctrlport.req;
    ram_ctrlport.req.wr = s_ctrlport.req.wr & ram_hit;
    ram_ctrlport.req.rd = s_ctrlport.req.rd & ram_hit;
  end

  // Unmapped access answered locally one cycle later
  always_ff @(posedge ctrlport_clk or negedge arst_n) begin
    if (!arst_n) begin
      miss_ack <= 1'b0;
    end else begin
      miss_ack <= strobe & ~cfg_hit & ~ram_hit;
    end
  end

  // AND-OR merge, valid since a single request is in flight
  always_comb begin
    s_ctrlport.resp.ack    = cfg_ctrlport.resp.ack | ram_ctrlport.resp.ack | miss_ack;
    s_ctrlport.resp.status = ctrlport_status_t'(
        ({2{cfg_ctrlport.resp.ack}} & cfg_ctrlport.resp.status) |
        ({2{ram_ctrlport.resp.ack}} & ram_ctrlport.resp.status) |
        ({2{miss_ack}} & SLVERR));
    // Miss data stays zero
    s_ctrlport.resp.data   =
        ({`CTRLPORT_DATA_W{cfg_ctrlport.resp.ack}} & cfg_ctrlport.resp.data) |
        ({`CTRLPORT_DATA_W{ram_ctrlport.resp.ack}} & ram_ctrlport.resp.data);
  end

endmodule

`default_nettype wire

//--- ctrlport_arbiter.sv
// **************************************************
// Merges master ports onto one downstream port under
// a run-time arbitration mode and enable mask
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

module ctrlport_arbiter
  import ctrlport_pkg::*;
  import subsys_regs_pkg::*;
#(
  parameter int NUM_MASTERS = `CTRLPORT_NUM_MASTERS
) (
  input  logic                   ctrlport_clk,
  input  logic                   arst_n,
  ctrlport_if.slave              s_ctrlport [NUM_MASTERS],
  ctrlport_if.master             m_ctrlport,
  input  arb_mode_t              mode,
  input  logic [NUM_MASTERS-1:0] master_en
);

  localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  ctrlport_req_t          live_req [NUM_MASTERS];
  ctrlport_req_t          held_req [NUM_MASTERS];
  ctrlport_req_t          sel_req  [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] strobe, pending, valid, cand, refuse_set;
  logic [NUM_MASTERS-1:0] grant_oh, refuse_oh, ack_q;
  logic [IDX_W-1:0]       owner, last_grant, win_idx, refuse_idx;
  logic                   busy, win_found, refuse_ok, ds_ack;

  // Downstream request register
  logic              ds_wr, ds_rd;
  ctrlport_addr_t    ds_addr;
  ctrlport_data_t    ds_data;
  ctrlport_byte_en_t ds_byte_en;

  // Shared response payload, only one master acked per cycle
  ctrlport_status_t resp_status_q;
  ctrlport_data_t   resp_data_q;

  for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_port
    assign live_req[i] = s_ctrlport[i].req;
    assign strobe[i]   = live_req[i].wr | live_req[i].rd;
    // A fresh strobe bypasses the holding register
    assign sel_req[i]  = strobe[i] ? live_req[i] : held_req[i];
    assign s_ctrlport[i].resp = '{ack: ack_q[i], status: resp_status_q, data: resp_data_q};
  end

  assign valid      = strobe | pending;
  assign cand       = valid & master_en;
  assign refuse_set = valid & ~master_en;
  assign ds_ack     = busy & m_ctrlport.resp.ack;

  // Winner pick, loops run backwards so the first in order wins
  always_comb begin
    int idx;
    win_found = 1'b0;
    win_idx   = '0;
    idx       = 0;
    if (mode == PRIORITY) begin
      // Lowest index first, fixed latency when uncontended
      for (int i = NUM_MASTERS-1; i >= 0; i--) begin
        if (cand[i]) begin
          win_found = 1'b1;
          win_idx   = IDX_W'(i);
        end
      end
    end else begin
      // Search starts just after the previous winner
      for (int k = NUM_MASTERS; k >= 1; k--) begin
        idx = int'(last_grant) + k;
        if (idx >= NUM_MASTERS) idx = idx - NUM_MASTERS;
        if (cand[idx]) begin
          win_found = 1'b1;
          win_idx   = IDX_W'(idx);
        end
      end
    end
  end

  // Disabled master to refuse, lowest index first
  always_comb begin
    refuse_idx = '0;
    for (int i = NUM_MASTERS-1; i >= 0; i--) begin
      if (refuse_set[i]) refuse_idx = IDX_W'(i);
    end
  end

  // Refusal waits while a downstream ack takes the response slot
  assign refuse_ok = (|refuse_set) & ~ds_ack;
  assign grant_oh  = (!busy && win_found) ? NUM_MASTERS'(1) << win_idx : '0;
  assign refuse_oh = refuse_ok ? NUM_MASTERS'(1) << refuse_idx : '0;

  always_ff @(posedge ctrlport_clk or negedge arst_n) begin
    if (!arst_n) begin
      pending    <= '0;
      busy       <= 1'b0;
      owner      <= '0;
      last_grant <= IDX_W'(NUM_MASTERS-1);
      ds_wr      <= 1'b0;
      ds_rd      <= 1'b0;
      ack_q      <= '0;
    end else begin
      // Anything not served this cycle stays pending
      pending <= valid & ~grant_oh & ~refuse_oh;
      ds_wr   <= 1'b0;
      ds_rd   <= 1'b0;
      if (!busy && win_found) begin
        ds_wr      <= sel_req[win_idx].wr;
        ds_rd      <= sel_req[win_idx].rd;
        busy       <= 1'b1;
        owner      <= win_idx;
        last_grant <= win_idx;
      end else if (ds_ack) begin
        busy <= 1'b0;
      end
      // Ack back to the owner one cycle after the target ack
      ack_q <= (ds_ack ? NUM_MASTERS'(1) << owner : '0) | refuse_oh;
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (strobe[i]) held_req[i] <= live_req[i];
    end
    if (!busy && win_found) begin
      ds_addr    <= sel_req[win_idx].addr;
      ds_data    <= sel_req[win_idx].data;
      ds_byte_en <= sel_req[win_idx].byte_en;
    end
    if (ds_ack) begin
      resp_status_q <= m_ctrlport.resp.status;
      resp_data_q   <= m_ctrlport.resp.data;
    end else if (refuse_ok) begin
      resp_status_q <= CMDERR;
      resp_data_q   <= '0;
    end
  end

  assign m_ctrlport.req = '{wr: ds_wr, rd: ds_rd, addr: ds_addr,
                            data: ds_data, byte_en: ds_byte_en};

endmodule

`default_nettype wire

//--- ctrlport_if.sv
// **************************************************
// Control-port link: one request and one response
// **************************************************
`default_nettype none

interface ctrlport_if
  import ctrlport_pkg::*;
();

  // Request from master, response from target
  ctrlport_req_t  req;
  ctrlport_resp_t resp;

  // Requester side
  modport master (
    output req,
    input  resp
  );

  // Target side
  modport slave (
    input  req,
    output resp
  );

endinterface

`default_nettype wire

//--- subsys_regs_pkg.sv
// **************************************************
// Register map types for the arbiter control word
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

package subsys_regs_pkg;

  typedef enum logic {
    ROUND_ROBIN = 1'b0,
    PRIORITY    = 1'b1
  } arb_mode_t;

  // Field view of ARB_CTRL: mode in bit 0, enable mask from bit 8
  typedef struct packed {
    logic [23-`CTRLPORT_NUM_MASTERS:0] rsvd_hi;
    logic [`CTRLPORT_NUM_MASTERS-1:0]  master_en;
    logic [6:0]                        rsvd_lo;
    arb_mode_t                         mode;
  } arb_ctrl_fields_t;

  // Same word seen raw on the bus or split into fields
  typedef union packed {
    logic [31:0]      raw;
    arb_ctrl_fields_t f;
  } arb_ctrl_u;

  // Writable bits, everything else reads as zero
  localparam logic [31:0] ARB_CTRL_MASK =
    {{(24-`CTRLPORT_NUM_MASTERS){1'b0}}, {`CTRLPORT_NUM_MASTERS{1'b1}}, 7'b0, 1'b1};

  // Round robin with every master enabled
  localparam logic [31:0] ARB_CTRL_RESET =
    {{(24-`CTRLPORT_NUM_MASTERS){1'b0}}, {`CTRLPORT_NUM_MASTERS{1'b1}}, 7'b0, 1'b0};

endpackage

`default_nettype wire

//--- ctrlport_pkg.sv
// **************************************************
// Control-port bus types: request, response, status
// **************************************************
`include "ctrlport_config.svh"
`default_nettype none

package ctrlport_pkg;

  typedef logic [`CTRLPORT_ADDR_W-1:0]    ctrlport_addr_t;
  typedef logic [`CTRLPORT_DATA_W-1:0]    ctrlport_data_t;
  typedef logic [`CTRLPORT_BYTE_EN_W-1:0] ctrlport_byte_en_t;

  // Response status codes, TSERR kept for encoding only
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    CMDERR = 2'b01,
    TSERR  = 2'b10,
    SLVERR = 2'b11
  } ctrlport_status_t;

  // One-cycle strobe request, wr and rd exclusive
  typedef struct packed {
    logic              wr;
    logic              rd;
    ctrlport_addr_t    addr;
    ctrlport_data_t    data;
    ctrlport_byte_en_t byte_en;
  } ctrlport_req_t;

  typedef struct packed {
    logic             ack;
    ctrlport_status_t status;
    ctrlport_data_t   data;
  } ctrlport_resp_t;

  // Replace the enabled bytes of a stored word
  function automatic ctrlport_data_t byte_merge(
    input ctrlport_data_t    old_word,
    input ctrlport_data_t    new_word,
    input ctrlport_byte_en_t byte_en
  );
    ctrlport_data_t result;
    result = old_word;
    for (int b = 0; b < `CTRLPORT_BYTE_EN_W; b++) begin
      if (byte_en[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire

//--- ctrlport_config.svh
// **************************************************
// Control-port subsystem build parameters
// **************************************************
`ifndef CTRLPORT_CONFIG_SVH
`define CTRLPORT_CONFIG_SVH
`default_nettype none

// Bus geometry
`define CTRLPORT_NUM_MASTERS 2
`define CTRLPORT_ADDR_W      20
`define CTRLPORT_DATA_W      32
`define CTRLPORT_BYTE_EN_W   4

// Address map, each window spans 2**WIN_W bytes
`define WIN_W     8
`define CFG_BASE  20'h00000
`define RAM_BASE  20'h00100
`define RAM_DEPTH 64

// Register offsets inside the configuration window
`define ARB_CTRL_OFS  8'h00
`define SCRATCH_OFS   8'h04
`define SCRATCH_WORDS 4

`default_nettype wire
`endif
